// ==== vlsu_pkg.sv ====
package vlsu_pkg;

    // lane and datapath sizing
    localparam int NUM_LANES   = 4;
    localparam int WORD_W      = 32;
    localparam int MEM_CREDITS = 2;
    localparam int LANE_W      = 2;

    // byte lanes inside one word
    localparam int BE_W  = WORD_W / 8;
    localparam int OFF_W = $clog2(BE_W);

    // counter widths, each holds its maximum value
    localparam int CNT_W    = $clog2(NUM_LANES + 1);
    localparam int CREDIT_W = $clog2(MEM_CREDITS + 1);

    localparam logic [LANE_W-1:0]   LAST_LANE   = LANE_W'(NUM_LANES - 1);
    localparam logic [CREDIT_W-1:0] CREDIT_INIT = CREDIT_W'(MEM_CREDITS);

    typedef enum logic [1:0] {
        EEW8  = 2'd0,
        EEW16 = 2'd1,
        EEW32 = 2'd2
    } eew_t;

    typedef enum logic {
        STRIDED = 1'b0,
        INDEXED = 1'b1
    } addr_mode_t;

    // one word per lane
    typedef logic [NUM_LANES-1:0][WORD_W-1:0] vec_data_t;

    typedef struct packed {
        logic                  is_store;
        addr_mode_t            mode;
        eew_t                  eew;
        logic [NUM_LANES-1:0]  mask;
        logic [WORD_W-1:0]     base;
        logic [WORD_W-1:0]     stride;
        vec_data_t             index;
        vec_data_t             store_data;
    } vec_cmd_t;

    // current lane as presented by the serializer
    typedef struct packed {
        logic               valid;
        logic [LANE_W-1:0]  lane;
        logic [WORD_W-1:0]  addr;
        logic               is_store;
        eew_t               eew;
    } lane_step_t;

    typedef struct packed {
        logic               valid;
        logic               write;
        logic [LANE_W-1:0]  lane;
        logic [WORD_W-1:0]  addr;
        logic [BE_W-1:0]    be;
        logic [WORD_W-1:0]  wdata;
    } mem_req_t;

    typedef struct packed {
        logic               valid;
        logic [LANE_W-1:0]  lane;
        logic [WORD_W-1:0]  rdata;
    } mem_rsp_t;

endpackage

// ==== vlsu_lane_serializer.sv ====
`timescale 1ns/10ps

module vlsu_lane_serializer (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         cmd_valid,
    input  vlsu_pkg::vec_cmd_t           cmd,
    input  logic                         can_issue,
    input  logic                         all_done,
    output vlsu_pkg::lane_step_t         step,
    output logic                         lane_mask_bit,
    output logic [vlsu_pkg::WORD_W-1:0]  lane_data,
    output logic                         busy,
    output logic                         walk_end
);

    // TAIL covers the cycle in which the last lane's request is on the bus
    typedef enum logic [1:0] {
        SER_IDLE,
        SER_WALK,
        SER_TAIL,
        SER_DRAIN
    } ser_state_t;

    ser_state_t                     state;
    ser_state_t                     next_state;
    vlsu_pkg::vec_cmd_t             cmd_q;
    logic [vlsu_pkg::LANE_W-1:0]    lane_q;
    logic [vlsu_pkg::WORD_W-1:0]    run_addr;
    logic [vlsu_pkg::WORD_W-1:0]    lane_addr;
    logic                           walking;
    logic                           advance;
    logic                           last_lane;

    assign walking       = (state == SER_WALK);
    assign last_lane     = (lane_q == vlsu_pkg::LAST_LANE);
    assign lane_mask_bit = cmd_q.mask[lane_q];
    assign lane_data     = cmd_q.store_data[lane_q];
    assign busy          = (state != SER_IDLE);

    // masked lanes step on without waiting for a credit
    assign advance = walking & (~lane_mask_bit | can_issue);

    // a masked last lane ends the walk at once and an active one a cycle later
    assign walk_end = (state == SER_TAIL) | (advance & last_lane & ~lane_mask_bit);

    always_comb begin
        if (cmd_q.mode == vlsu_pkg::INDEXED) begin
            lane_addr = cmd_q.base + cmd_q.index[lane_q];
        end else begin
            lane_addr = run_addr;
        end
    end

    always_comb begin
        step          = '0;
        step.valid    = walking & lane_mask_bit;
        step.lane     = lane_q;
        step.addr     = lane_addr;
        step.is_store = cmd_q.is_store;
        step.eew      = cmd_q.eew;
    end

    always_comb begin
        next_state = state;
        case (state)
            SER_IDLE: begin
                if (cmd_valid) begin
                    next_state = SER_WALK;
                end
            end
            SER_WALK: begin
                if (advance & last_lane) begin
                    next_state = step.valid ? SER_TAIL : SER_DRAIN;
                end
            end
            SER_TAIL: begin
                next_state = SER_DRAIN;
            end
            default: begin
                next_state = state;
            end
        endcase
        // collector reports every answer in
        if (all_done) begin
            next_state = SER_IDLE;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            state  <= SER_IDLE;
            lane_q <= '0;
        end else begin
            state <= next_state;
            if (state == SER_IDLE) begin
                lane_q <= '0;
            end else if (advance) begin
                lane_q <= lane_q + 1'b1;
            end
        end
    end

    // command and strided running address
    always_ff @(posedge CLK) begin
        if ((state == SER_IDLE) && cmd_valid) begin
            cmd_q    <= cmd;
            run_addr <= cmd.base;
        end else if (advance) begin
            run_addr <= run_addr + cmd_q.stride;
        end
    end

    // only one command in flight
    assert property (@(posedge CLK) disable iff (~nRST) cmd_valid |-> ~busy)
        else $error("vector command while busy");

endmodule

// ==== vlsu_store_align.sv ====
`timescale 1ns/10ps

module vlsu_store_align (
    input  vlsu_pkg::lane_step_t         step,
    input  logic [vlsu_pkg::WORD_W-1:0]  lane_data,
    output logic [vlsu_pkg::WORD_W-1:0]  wdata
);

    logic [7:0]  elem_b;
    logic [15:0] elem_h;

    assign elem_b = lane_data[7:0];
    assign elem_h = lane_data[15:0];

    // copy the element into every byte position it could occupy,
    // the byte enables then pick the right one
    always_comb begin
        case (step.eew)
            vlsu_pkg::EEW8: begin
                wdata = {4{elem_b}};
            end
            vlsu_pkg::EEW16: begin
                wdata = {2{elem_h}};
            end
            default: begin
                wdata = lane_data;
            end
        endcase
    end

endmodule

// ==== vlsu_credit_port.sv ====
`timescale 1ns/10ps

module vlsu_credit_port (
    input  logic                         CLK,
    input  logic                         nRST,
    input  vlsu_pkg::lane_step_t         step,
    input  logic                         lane_mask_bit,
    input  logic [vlsu_pkg::WORD_W-1:0]  wdata,
    input  logic                         mem_credit,
    output logic                         can_issue,
    output vlsu_pkg::mem_req_t           mem_req
);

    logic [vlsu_pkg::CREDIT_W-1:0]  credit_cnt;
    logic [vlsu_pkg::BE_W-1:0]      be;
    logic                           issue;
    logic                           req_valid_q;
    vlsu_pkg::mem_req_t             req_q;

    assign can_issue = (credit_cnt != '0);
    assign issue     = step.valid & lane_mask_bit & can_issue;

    // byte enables from element width and byte offset
    always_comb begin
        case (step.eew)
            vlsu_pkg::EEW8: begin
                be = 4'b0001 << step.addr[vlsu_pkg::OFF_W-1:0];
            end
            vlsu_pkg::EEW16: begin
                be = 4'b0011 << {step.addr[1], 1'b0};
            end
            default: begin
                be = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            credit_cnt  <= vlsu_pkg::CREDIT_INIT;
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= issue;
            case ({issue, mem_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (issue) begin
            req_q.valid <= 1'b1;
            req_q.write <= step.is_store;
            req_q.lane  <= step.lane;
            req_q.addr  <= step.addr;
            req_q.be    <= be;
            // loads put nothing on the data lines
            req_q.wdata <= step.is_store ? wdata : '0;
        end
    end

    always_comb begin
        mem_req       = req_q;
        mem_req.valid = req_valid_q;
    end

    // memory never returns more credits than it was given
    assert property (@(posedge CLK) disable iff (~nRST)
        (mem_credit & ~issue) |-> (credit_cnt < vlsu_pkg::CREDIT_INIT))
        else $error("credit count overflow");

    // serializer addresses must be naturally aligned
    assert property (@(posedge CLK) disable iff (~nRST)
        issue |-> ((step.eew == vlsu_pkg::EEW8) ||
                   ((step.eew == vlsu_pkg::EEW16) && ~step.addr[0]) ||
                   (step.addr[1:0] == 2'b00)))
        else $error("misaligned element address");

endmodule

// ==== vlsu_load_collect.sv ====
`timescale 1ns/10ps

module vlsu_load_collect (
    input  logic                CLK,
    input  logic                nRST,
    input  vlsu_pkg::mem_req_t  mem_req,
    input  vlsu_pkg::mem_rsp_t  mem_rsp,
    input  logic                walk_end,
    input  vlsu_pkg::eew_t      eew,
    output logic                all_done,
    output logic                done,
    output vlsu_pkg::vec_data_t result
);

    logic [vlsu_pkg::CNT_W-1:0]                      issued_cnt;
    logic [vlsu_pkg::CNT_W-1:0]                      rsp_cnt;
    logic [vlsu_pkg::CNT_W-1:0]                      issued_next;
    logic [vlsu_pkg::CNT_W-1:0]                      rsp_next;
    logic [vlsu_pkg::NUM_LANES-1:0][vlsu_pkg::OFF_W-1:0] off_q;
    logic [vlsu_pkg::WORD_W-1:0]                     shifted;
    logic [vlsu_pkg::WORD_W-1:0]                     elem;
    logic                                            active_q;
    logic                                            walked_q;
    logic                                            wr_q;
    logic                                            start;
    logic                                            fin;

    // first request or an empty walk opens a new command
    assign start = ~active_q & (mem_req.valid | walk_end);

    assign issued_next = issued_cnt + {{(vlsu_pkg::CNT_W-1){1'b0}}, mem_req.valid};
    assign rsp_next    = rsp_cnt + {{(vlsu_pkg::CNT_W-1){1'b0}}, mem_rsp.valid};

    // counts include this cycle's traffic so done follows the last response
    assign fin      = (walked_q | walk_end) & (issued_next == rsp_next);
    assign all_done = fin;

    // element extraction, zero extended
    assign shifted = mem_rsp.rdata >> {off_q[mem_rsp.lane], 3'b000};

    always_comb begin
        case (eew)
            vlsu_pkg::EEW8:  elem = {{(vlsu_pkg::WORD_W-8){1'b0}}, shifted[7:0]};
            vlsu_pkg::EEW16: elem = {{(vlsu_pkg::WORD_W-16){1'b0}}, shifted[15:0]};
            default:         elem = shifted;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (~nRST) begin
            active_q   <= 1'b0;
            walked_q   <= 1'b0;
            issued_cnt <= '0;
            rsp_cnt    <= '0;
            done       <= 1'b0;
        end else begin
            done <= fin;
            if (fin) begin
                active_q   <= 1'b0;
                walked_q   <= 1'b0;
                issued_cnt <= '0;
                rsp_cnt    <= '0;
            end else begin
                if (start) begin
                    active_q <= 1'b1;
                end
                if (walk_end) begin
                    walked_q <= 1'b1;
                end
                issued_cnt <= issued_next;
                rsp_cnt    <= rsp_next;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (mem_req.valid) begin
            off_q[mem_req.lane] <= mem_req.addr[vlsu_pkg::OFF_W-1:0];
            wr_q                <= mem_req.write;
        end
        // masked lanes stay at zero
        if (start) begin
            result <= '0;
        end
        if (mem_rsp.valid & ~wr_q) begin
            result[mem_rsp.lane] <= elem;
        end
    end

    // no response without an outstanding request
    assert property (@(posedge CLK) disable iff (~nRST)
        mem_rsp.valid |-> (issued_cnt != rsp_cnt))
        else $error("unexpected memory response");

endmodule

// ==== vlsu_top.sv ====
`timescale 1ns/10ps

module vlsu_top (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 cmd_valid,
    input  vlsu_pkg::vec_cmd_t   cmd,
    input  logic                 mem_credit,
    input  vlsu_pkg::mem_rsp_t   mem_rsp,
    output logic                 busy,
    output vlsu_pkg::mem_req_t   mem_req,
    output logic                 done,
    output vlsu_pkg::vec_data_t  result
);

    vlsu_pkg::lane_step_t         step;
    logic                         lane_mask_bit;
    logic [vlsu_pkg::WORD_W-1:0]  lane_data;
    logic [vlsu_pkg::WORD_W-1:0]  wdata;
    logic                         can_issue;
    logic                         all_done;
    logic                         walk_end;

    vlsu_lane_serializer serializer_i (
        .CLK           (CLK),
        .nRST          (nRST),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .can_issue     (can_issue),
        .all_done      (all_done),
        .step          (step),
        .lane_mask_bit (lane_mask_bit),
        .lane_data     (lane_data),
        .busy          (busy),
        .walk_end      (walk_end)
    );

    vlsu_store_align store_align_i (
        .step      (step),
        .lane_data (lane_data),
        .wdata     (wdata)
    );

    vlsu_credit_port credit_port_i (
        .CLK           (CLK),
        .nRST          (nRST),
        .step          (step),
        .lane_mask_bit (lane_mask_bit),
        .wdata         (wdata),
        .mem_credit    (mem_credit),
        .can_issue     (can_issue),
        .mem_req       (mem_req)
    );

    // element width stays latched in the serializer until the next command
    vlsu_load_collect load_collect_i (
        .CLK      (CLK),
        .nRST     (nRST),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp),
        .walk_end (walk_end),
        .eew      (step.eew),
        .all_done (all_done),
        .done     (done),
        .result   (result)
    );

endmodule

// ==== tb_vlsu.sv ====
`timescale 1ns/10ps

module tb_vlsu;

    localparam int NUM_CMDS   = 200;
    localparam int CMD_CYCLES = vlsu_pkg::NUM_LANES * 5 + 10;
    localparam int TIMEOUT    = NUM_CMDS * CMD_CYCLES;
    localparam int MEM_WORDS  = 64;

    // response waiting in the memory model until its cycle comes up
    typedef struct packed {
        logic [31:0]         due;
        vlsu_pkg::mem_rsp_t  rsp;
    } pending_rsp_t;

    logic                  CLK = 1'b0;
    logic                  nRST;
    logic                  cmd_valid;
    vlsu_pkg::vec_cmd_t    cmd;
    logic                  mem_credit;
    vlsu_pkg::mem_rsp_t    mem_rsp;
    logic                  busy;
    vlsu_pkg::mem_req_t    mem_req;
    logic                  done;
    vlsu_pkg::vec_data_t   result;

    logic [31:0]           lcg_state;
    logic [31:0]           mem [MEM_WORDS];
    logic [31:0]           ref_mem [MEM_WORDS];
    vlsu_pkg::mem_req_t    exp_q[$];
    pending_rsp_t          rsp_q[$];
    vlsu_pkg::vec_data_t   exp_result;
    vlsu_pkg::vec_cmd_t    next_cmd;
    string                 test_name;
    int                    cycle_cnt = 0;
    int                    neg_cnt = 0;
    int                    outstanding = 0;
    int                    cmds_sent = 0;
    int                    dones_seen = 0;

    vlsu_top vlsu_top_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .mem_credit (mem_credit),
        .mem_rsp    (mem_rsp),
        .busy       (busy),
        .mem_req    (mem_req),
        .done       (done),
        .result     (result)
    );

    always #20 CLK = ~CLK;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // low bits of an LCG repeat quickly so take the upper half
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[31:16]) % n;
    endfunction

    function automatic logic [3:0] byte_enables(input vlsu_pkg::eew_t eew, input logic [1:0] off);
        logic [3:0] be;
        case (eew)
            vlsu_pkg::EEW8:  be = 4'b0001 << off;
            vlsu_pkg::EEW16: be = 4'b0011 << off;
            default:         be = 4'b1111;
        endcase
        return be;
    endfunction

    function automatic logic [31:0] replicate_elem(input vlsu_pkg::eew_t eew,
                                                   input logic [31:0] d);
        logic [31:0] w;
        case (eew)
            vlsu_pkg::EEW8:  w = {4{d[7:0]}};
            vlsu_pkg::EEW16: w = {2{d[15:0]}};
            default:         w = d;
        endcase
        return w;
    endfunction

    function automatic logic [31:0] extract_elem(input vlsu_pkg::eew_t eew,
                                                 input logic [31:0] word,
                                                 input logic [1:0] off);
        logic [31:0] s;
        logic [31:0] e;
        s = word >> (8 * off);
        case (eew)
            vlsu_pkg::EEW8:  e = {24'h0, s[7:0]};
            vlsu_pkg::EEW16: e = {16'h0, s[15:0]};
            default:         e = s;
        endcase
        return e;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wd,
                                                input logic [3:0] be);
        logic [31:0] w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return w;
    endfunction

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_req(input string name, input vlsu_pkg::mem_req_t exp,
                             input vlsu_pkg::mem_req_t act);
        logic bad;
        // write data is only defined for stores
        bad = (exp.valid != act.valid) || (exp.write != act.write) ||
              (exp.lane != act.lane) || (exp.addr != act.addr) || (exp.be != act.be) ||
              (exp.write && (exp.wdata != act.wdata));
        if (bad) begin
            $display("[ERROR] %s request: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_result(input string name, input vlsu_pkg::vec_data_t exp,
                                input vlsu_pkg::vec_data_t act);
        if (exp != act) begin
            $display("[ERROR] %s result: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input int idx, input logic [31:0] exp,
                              input logic [31:0] act);
        if (exp != act) begin
            $display("[ERROR] %s memory word %0d: expected %h, actual %h", name, idx, exp, act);
            abort_run();
        end
    endtask

    // random command with every address aligned and inside the memory model
    task automatic build_cmd(input int n);
        int          esz;
        int          units;
        logic [31:0] lo;
        logic [31:0] hi;
        next_cmd          = '0;
        next_cmd.is_store = 1'(rand_below(2));
        next_cmd.mode     = vlsu_pkg::addr_mode_t'(1'(rand_below(2)));
        next_cmd.eew      = vlsu_pkg::eew_t'(2'(rand_below(3)));
        esz = 1 << next_cmd.eew;
        if (n % 10 == 7) begin
            next_cmd.mask = 4'h0;
        end else if (n % 2 == 0) begin
            next_cmd.mask = 4'hF;
        end else begin
            next_cmd.mask = 4'(rand_below(16));
        end
        if (next_cmd.mode == vlsu_pkg::STRIDED) begin
            units           = rand_below(16);
            next_cmd.stride = 32'(units * esz);
            next_cmd.base   = 32'(rand_below(MEM_WORDS * 4 / esz - 3 * units) * esz);
        end else begin
            next_cmd.base = 32'(rand_below(MEM_WORDS * 2 / esz) * esz);
            for (int lane = 0; lane < vlsu_pkg::NUM_LANES; lane++) begin
                next_cmd.index[lane] = 32'(rand_below(MEM_WORDS * 2 / esz) * esz);
            end
        end
        for (int lane = 0; lane < vlsu_pkg::NUM_LANES; lane++) begin
            lo = next_rand();
            hi = next_rand();
            next_cmd.store_data[lane] = {hi[31:16], lo[31:16]};
        end
        test_name = $sformatf("%s_%s_eew%0d #%0d",
                              (next_cmd.mode == vlsu_pkg::INDEXED) ? "indexed" : "strided",
                              next_cmd.is_store ? "store" : "load", 8 * esz, n);
    endtask

    // reference model for the requests in lane order and the load result
    task automatic compute_expected();
        vlsu_pkg::mem_req_t r;
        logic [31:0]        addr;
        logic [5:0]         w;
        exp_q.delete();
        exp_result = '0;
        for (int lane = 0; lane < vlsu_pkg::NUM_LANES; lane++) begin
            if (next_cmd.mode == vlsu_pkg::INDEXED) begin
                addr = next_cmd.base + next_cmd.index[lane];
            end else begin
                addr = next_cmd.base + 32'(lane) * next_cmd.stride;
            end
            w = addr[7:2];
            if (next_cmd.mask[lane]) begin
                r       = '0;
                r.valid = 1'b1;
                r.write = next_cmd.is_store;
                r.lane  = 2'(lane);
                r.addr  = addr;
                r.be    = byte_enables(next_cmd.eew, addr[1:0]);
                if (next_cmd.is_store) begin
                    r.wdata    = replicate_elem(next_cmd.eew, next_cmd.store_data[lane]);
                    ref_mem[w] = merge_bytes(ref_mem[w], r.wdata, r.be);
                end else begin
                    exp_result[lane] = extract_elem(next_cmd.eew, ref_mem[w], addr[1:0]);
                end
                exp_q.push_back(r);
            end
        end
    endtask

    // memory model and bus monitor sample on the falling edge
    always @(negedge CLK) begin
        pending_rsp_t       p;
        vlsu_pkg::mem_req_t exp_req;
        neg_cnt++;
        if (done) begin
            if (dones_seen >= cmds_sent) begin
                $display("done pulsed while no command was pending");
                abort_run();
            end
            if ((exp_q.size() != 0) || (rsp_q.size() != 0)) begin
                $display("done arrived before every request was issued and answered in %s",
                         test_name);
                abort_run();
            end
            if (busy) begin
                $display("busy still high in the done cycle of %s", test_name);
                abort_run();
            end
            if (cmd.is_store) begin
                for (int i = 0; i < MEM_WORDS; i++) begin
                    check_word(test_name, i, ref_mem[i], mem[i]);
                end
            end else begin
                check_result(test_name, exp_result, result);
            end
            dones_seen++;
        end
        if (mem_req.valid) begin
            if (exp_q.size() == 0) begin
                $display("memory request with none expected in %s", test_name);
                abort_run();
            end
            exp_req = exp_q.pop_front();
            check_req(test_name, exp_req, mem_req);
            outstanding++;
            if (outstanding > vlsu_pkg::MEM_CREDITS) begin
                $display("more requests outstanding than credits in %s", test_name);
                abort_run();
            end
            p           = '0;
            p.due       = 32'(neg_cnt + 1 + rand_below(4));
            p.rsp.valid = 1'b1;
            p.rsp.lane  = mem_req.lane;
            if (mem_req.write) begin
                mem[mem_req.addr[7:2]] = merge_bytes(mem[mem_req.addr[7:2]], mem_req.wdata,
                                                     mem_req.be);
            end else begin
                p.rsp.rdata = mem[mem_req.addr[7:2]];
            end
            rsp_q.push_back(p);
        end
        // responses in order and at most one per cycle with its credit
        mem_rsp    = '0;
        mem_credit = 1'b0;
        if ((rsp_q.size() != 0) && (rsp_q[0].due <= 32'(neg_cnt))) begin
            p          = rsp_q.pop_front();
            mem_rsp    = p.rsp;
            mem_credit = 1'b1;
            outstanding--;
        end
    end

    always @(posedge CLK) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT) begin
            $display("timeout after %0d cycles", TIMEOUT);
            abort_run();
        end
    end

    initial begin
        int wait_cnt;
        lcg_state  = 32'h1352;
        nRST       = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = '0;
        mem_credit = 1'b0;
        mem_rsp    = '0;
        test_name  = "reset";
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = 32'h9E3779B9 * 32'(i + 1);
            ref_mem[i] = mem[i];
        end
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);
        if (busy || done || mem_req.valid) begin
            $display("outputs not idle after reset");
            abort_run();
        end
        for (int n = 0; n < NUM_CMDS; n++) begin
            @(posedge CLK);
            build_cmd(n);
            compute_expected();
            @(negedge CLK);
            cmd       = next_cmd;
            cmd_valid = 1'b1;
            cmds_sent++;
            @(negedge CLK);
            cmd_valid = 1'b0;
            if (!busy) begin
                $display("busy did not rise after %s was accepted", test_name);
                abort_run();
            end
            wait_cnt  = 0;
            while (dones_seen != n + 1) begin
                @(posedge CLK);
                wait_cnt++;
                if (wait_cnt > CMD_CYCLES) begin
                    $display("done never arrived for %s", test_name);
                    abort_run();
                end
            end
        end
        @(negedge CLK);
        if ((outstanding != 0) || (rsp_q.size() != 0) || done) begin
            $display("memory traffic left over at the end of the run");
            abort_run();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
vlsu_pkg.sv
vlsu_lane_serializer.sv
vlsu_store_align.sv
vlsu_credit_port.sv
vlsu_load_collect.sv
vlsu_top.sv
tb_vlsu.sv

// ==== Makefile ====
TOP = tb_vlsu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
